/* Makefile */
# Verilator build and run for the fc2 output stage

VERILATOR ?= verilator
TOP       ?= fc2_subsystem_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  := *** TEST FAILED ***

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# a crash of the simulator counts as a failure too
run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || echo '$(FAIL_MSG)' >> $(LOG)
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/bram_wr_if.sv */
// write port bundle between the fc2 result writer and the row memory
`timescale 1ns/1ns

interface bram_wr_if;

    // row address
    logic [fc2_pkg::ROW_AW-1:0] addr;
    // chip enable
    logic                       ce;
    // write enable, a row is written when ce and we are both high
    logic                       we;
    // row data, first result in the top byte
    logic [fc2_pkg::ROW_W-1:0]  d;

    // result writer side drives the whole port
    modport writer (
        output addr,
        output ce,
        output we,
        output d
    );

    // memory side only samples
    modport memory (
        input addr,
        input ce,
        input we,
        input d
    );

endinterface

/* logic/fc2_mac_unit.sv */
// fc2 multiply-accumulate unit, quantizes each dot product to one unsigned byte
`timescale 1ns/1ns

module fc2_mac_unit (
    input  logic                              clk,
    input  logic                              reset_n,
    // input beat stream, no back-pressure
    input  logic                              in_valid_i,
    input  logic                              in_last_i,
    input  logic signed [fc2_pkg::DIN_W-1:0]  feature_i,
    input  logic signed [fc2_pkg::DIN_W-1:0]  weight_i,
    // one-cycle done pulse, result valid only with it
    output logic                              calc_done_o,
    output logic        [fc2_pkg::RES_W-1:0]  calc_result_o
);

    // running sum of the current dot product
    logic signed [fc2_pkg::ACC_W-1:0]   acc;
    // product of the current beat
    logic signed [2*fc2_pkg::DIN_W-1:0] prod;
    // sum including the current beat
    logic signed [fc2_pkg::ACC_W-1:0]   sum_next;
    // sum after the quantization shift
    logic signed [fc2_pkg::ACC_W-1:0]   shifted;
    // clamped result
    logic        [fc2_pkg::RES_W-1:0]   quant;
    // last beat of a dot product seen this cycle
    logic                               last_beat;

    assign last_beat = in_valid_i && in_last_i;

    // both operands signed, product sign-extends into the accumulator
    assign prod     = feature_i * weight_i;
    assign sum_next = acc + prod;
    assign shifted  = sum_next >>> fc2_pkg::QUANT_SHIFT;

    // relu then clamp to the ceiling
    always_comb begin
        if (shifted[fc2_pkg::ACC_W-1]) begin
            quant = '0;
        end else if (shifted > {{(fc2_pkg::ACC_W - fc2_pkg::RES_W){1'b0}}, fc2_pkg::RES_MAX}) begin
            quant = fc2_pkg::RES_MAX;
        end else begin
            quant = shifted[fc2_pkg::RES_W-1:0];
        end
    end

    // accumulator restarts at the edge that closes a dot product
    // so the next beat right after the last one starts a fresh sum
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc         <= '0;
            calc_done_o <= 1'b0;
        end else begin
            calc_done_o <= last_beat;
            if (last_beat) begin
                acc <= '0;
            end else if (in_valid_i) begin
                acc <= sum_next;
            end
        end
    end

    // result register, only meaningful while the done pulse is high
    always_ff @(posedge clk) begin
        if (last_beat) begin
            calc_result_o <= quant;
        end
    end

endmodule

/* logic/fc2_pkg.sv */
// fc2 output stage shared widths, row geometry and quantization constants
package fc2_pkg;

    // one signed input operand, feature or weight
    localparam int DIN_W = 8;

    // accumulator, wide enough for long dot products of 8x8 products
    localparam int ACC_W = 24;

    // arithmetic right shift applied to the sum before clamping
    localparam int QUANT_SHIFT = 4;

    // one quantized unsigned result
    localparam int RES_W = 8;

    // clamp ceiling for a quantized result
    localparam logic [RES_W-1:0] RES_MAX = RES_W'(255);

    // row geometry of the result memory
    localparam int RES_PER_ROW = 5;
    localparam int ROW_W = RES_W * RES_PER_ROW;
    localparam int ROW_AW = 2;
    localparam int ROW_DEPTH = 1 << ROW_AW;

    // writer slot counter, counts 0 .. RES_PER_ROW-1
    localparam int SLOT_CNT_W = 3;
    localparam logic [SLOT_CNT_W-1:0] LAST_SLOT = SLOT_CNT_W'(RES_PER_ROW - 1);

endpackage

/* logic/fc2_result_bram.sv */
// fc2 result row memory with a write port via interface and a registered read port
`timescale 1ns/1ns

module fc2_result_bram (
    input  logic                        clk,
    // write-only port from the result writer
    bram_wr_if.memory                   wr,
    // read port for the outside world
    input  logic                        rd_en_i,
    input  logic [fc2_pkg::ROW_AW-1:0]  rd_addr_i,
    output logic [fc2_pkg::ROW_W-1:0]   rd_data_o
);

    // row storage in block ram style
    logic [fc2_pkg::ROW_W-1:0] mem [fc2_pkg::ROW_DEPTH];

    // write lands at the edge that ends the strobe cycle
    always_ff @(posedge clk) begin
        if (wr.ce && wr.we) begin
            mem[wr.addr] <= wr.d;
        end
    end

    // registered read with one cycle latency
    // output holds its last value while rd_en_i is low
    // a read to the row being written this cycle returns the old row
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* logic/fc2_result_writer.sv */
// fc2 result writer, packs five results per row and writes rows at a wrapping address
`timescale 1ns/1ns

module fc2_result_writer (
    input  logic                        clk,
    input  logic                        reset_n,
    // quantized results from the mac unit
    input  logic                        calc_done_i,
    input  logic [fc2_pkg::RES_W-1:0]   calc_result_i,
    // write port towards the row memory
    bram_wr_if.writer                   wr
);

    // row under assembly, newest result in the low byte
    logic [fc2_pkg::ROW_W-1:0]      row_asm;
    // assembled row with the current result shifted in
    logic [fc2_pkg::ROW_W-1:0]      row_next;
    // finished row held for the write cycle
    logic [fc2_pkg::ROW_W-1:0]      row_q;
    // results already captured in the current row
    logic [fc2_pkg::SLOT_CNT_W-1:0] slot_cnt;
    // current row address, wraps with its width
    logic [fc2_pkg::ROW_AW-1:0]     addr_q;
    // one-cycle write strobe
    logic                           wr_stb;
    // fifth result of a row arrives this cycle
    logic                           row_full;

    assign row_full = calc_done_i && (slot_cnt == fc2_pkg::LAST_SLOT);

    // shift-in assembly
    // after five shifts the first result sits in the top byte
    // and every bit of the previous row has been pushed out
    assign row_next = {row_asm[fc2_pkg::ROW_W-fc2_pkg::RES_W-1:0], calc_result_i};

    always_ff @(posedge clk) begin
        if (calc_done_i) begin
            row_asm <= row_next;
        end
        // own output register, a result in the write cycle cannot disturb it
        if (row_full) begin
            row_q <= row_next;
        end
    end

    // slot counter, strobe and address
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            slot_cnt <= '0;
            wr_stb   <= 1'b0;
            addr_q   <= '0;
        end else begin
            wr_stb <= row_full;
            if (row_full) begin
                slot_cnt <= '0;
            end else if (calc_done_i) begin
                slot_cnt <= slot_cnt + 1'b1;
            end
            // advance after the write cycle, 3 -> 0 by overflow
            if (wr_stb) begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    // ce and we pulse together
    assign wr.addr = addr_q;
    assign wr.ce   = wr_stb;
    assign wr.we   = wr_stb;
    assign wr.d    = row_q;

endmodule

/* logic/fc2_subsystem_top.sv */
// fc2 output stage top, mac unit feeding the result writer and the row memory
`timescale 1ns/1ns

module fc2_subsystem_top (
    input  logic                              clk,
    input  logic                              reset_n,
    // input beat stream
    input  logic                              in_valid_i,
    input  logic                              in_last_i,
    input  logic signed [fc2_pkg::DIN_W-1:0]  feature_i,
    input  logic signed [fc2_pkg::DIN_W-1:0]  weight_i,
    // row readback
    input  logic                              rd_en_i,
    input  logic        [fc2_pkg::ROW_AW-1:0] rd_addr_i,
    output logic        [fc2_pkg::ROW_W-1:0]  rd_data_o,
    // copy of the row write strobe
    output logic                              row_wr_o
);

    // mac to writer
    logic                      calc_done;
    logic [fc2_pkg::RES_W-1:0] calc_result;

    // writer to memory
    bram_wr_if wr_bus ();

    fc2_mac_unit u_mac (
        .clk           (clk),
        .reset_n       (reset_n),
        .in_valid_i    (in_valid_i),
        .in_last_i     (in_last_i),
        .feature_i     (feature_i),
        .weight_i      (weight_i),
        .calc_done_o   (calc_done),
        .calc_result_o (calc_result)
    );

    fc2_result_writer u_writer (
        .clk           (clk),
        .reset_n       (reset_n),
        .calc_done_i   (calc_done),
        .calc_result_i (calc_result),
        .wr            (wr_bus)
    );

    fc2_result_bram u_bram (
        .clk       (clk),
        .wr        (wr_bus),
        .rd_en_i   (rd_en_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

    // status strobe, high for the one write cycle of each row
    assign row_wr_o = wr_bus.we;

endmodule

/* project.f */
logic/fc2_pkg.sv
logic/bram_wr_if.sv
logic/fc2_mac_unit.sv
logic/fc2_result_writer.sv
logic/fc2_result_bram.sv
logic/fc2_subsystem_top.sv
tests/fc2_subsystem_tb.sv

/* tests/fc2_stimulus.txt */
# T <test> | B <feature> <weight> <last> | E <addr> <expected row>
# features and weights are signed 8-bit hex, rows are 40-bit hex, first result in the top byte
T 1
B 0a 10 1
B 14 10 1
B 1e 10 1
B 28 10 1
B 32 10 1
E 0 0a141e2832
T 2
B f0 10 1
B 07 09 0
B 0b 0d 1
B 7f 7f 1
B 80 80 0
B 80 7f 1
B ff 01 1
E 1 000cff0800
T 3
B 11 10 1
B 22 10 1
B 33 10 1
B 44 10 1
B 55 10 1
E 2 1122334455
T 4
B 41 10 1
B 42 10 1
B 43 10 1
B 44 10 1
B 45 10 1
B 51 10 1
B 52 10 1
B 53 10 1
B 54 10 1
B 55 10 1
B 61 10 1
B 62 10 1
B 63 10 1
B 64 10 1
B 65 10 1
E 0 5152535455
E 1 6162636465
E 2 1122334455
E 3 4142434445
T 5
B 71 10 1
B 72 10 1
B 73 10 1
B 74 10 1
B 75 10 1
B 76 10 1
B 77 10 1
B 78 10 1
B 79 10 1
B 7a 10 1
E 2 7172737475
E 3 767778797a
T 6
B 50 20 1
B 51 20 1
B 52 20 1
B 53 20 1
B 54 20 1
E 0 a0a2a4a6a8

/* tests/fc2_subsystem_tb.sv */
// fc2 output stage testbench that replays beats from the stimulus file and checks rows read back
`timescale 1ns/1ns

module fc2_subsystem_tb;

    logic                         clk;
    logic                         reset_n;
    logic                         in_valid_i;
    logic                         in_last_i;
    logic [fc2_pkg::DIN_W-1:0]    feature_i;
    logic [fc2_pkg::DIN_W-1:0]    weight_i;
    logic                         rd_en_i;
    logic [fc2_pkg::ROW_AW-1:0]   rd_addr_i;
    logic [fc2_pkg::ROW_W-1:0]    rd_data_o;
    logic                         row_wr_o;

    // one entry per data line with a kind letter and up to three fields
    byte         rec_kind [$];
    logic [63:0] rec_a [$];
    logic [63:0] rec_b [$];
    logic [63:0] rec_c [$];

    int          checks = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          beat_lines = 0;
    int          cur_test = 0;
    int          test_err0 = 0;
    int          lasts_driven = 0;
    int          lasts_seen = 0;
    int          writes_seen = 0;
    int          cyc = 0;
    bit          in_test = 0;
    bit          reading = 0;
    logic [31:0] seed = 32'h24f9765f;
    // expected strobe delayed by the mac and writer stages
    logic [1:0]  wr_pipe = 2'b00;
    // word the read port should still hold before the next read edge
    logic [fc2_pkg::ROW_W-1:0] last_rd;

    fc2_subsystem_top dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid_i (in_valid_i),
        .in_last_i  (in_last_i),
        .feature_i  (feature_i),
        .weight_i   (weight_i),
        .rd_en_i    (rd_en_i),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o),
        .row_wr_o   (row_wr_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          want;
        string       line;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        fd = $fopen("tests/fc2_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("stimulus file tests/fc2_stimulus.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                want = 0;
                a = '0;
                b = '0;
                c = '0;
                if (line.getc(0) == "T") begin
                    want = 1;
                    n = $sscanf(line, "T %d", a);
                end else if (line.getc(0) == "B") begin
                    want = 3;
                    n = $sscanf(line, "B %h %h %h", a, b, c);
                    beat_lines++;
                end else if (line.getc(0) == "E") begin
                    want = 2;
                    n = $sscanf(line, "E %h %h", a, b);
                end
                // comments and blank lines are dropped
                if (want != 0) begin
                    if (n != want) begin
                        errors++;
                        $display("stimulus line could not be parsed: %s", line);
                    end
                    rec_kind.push_back(line.getc(0));
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    rec_c.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    // a row strobe follows two cycles after the last beat of every fifth result
    always @(posedge clk) begin
        cyc++;
        if (cyc > 1) begin
            check_value("row_wr_o", 64'(row_wr_o), 64'(wr_pipe[1]));
        end
        if (row_wr_o) begin
            writes_seen++;
        end
        wr_pipe[1] = wr_pipe[0];
        wr_pipe[0] = in_valid_i && in_last_i && (lasts_seen % fc2_pkg::RES_PER_ROW == 4);
        if (in_valid_i && in_last_i) begin
            lasts_seen++;
        end
    end

    task automatic drive_beat(input logic [63:0] f, input logic [63:0] w,
                              input logic [63:0] l, input bit add_idle);
        int idle;
        idle = 0;
        if (add_idle) begin
            seed = lcg_next(seed);
            idle = int'(seed[17:16]);
        end
        // idle gaps go before the beat so that a last beat is followed directly by readback
        repeat (idle) begin
            @(posedge clk);
            in_valid_i <= 1'b0;
            in_last_i  <= 1'b0;
        end
        @(posedge clk);
        in_valid_i <= 1'b1;
        in_last_i  <= l[0];
        feature_i  <= f[fc2_pkg::DIN_W-1:0];
        weight_i   <= w[fc2_pkg::DIN_W-1:0];
        if (l[0]) begin
            lasts_driven++;
        end
    endtask

    // returns in the strobe cycle of the last expected row
    task automatic wait_for_rows();
        int waited;
        waited = 0;
        @(posedge clk);
        in_valid_i <= 1'b0;
        in_last_i  <= 1'b0;
        do begin
            @(negedge clk);
            waited++;
        end while (writes_seen + int'(row_wr_o) < lasts_driven / 5 && waited < 20);
        if (writes_seen + int'(row_wr_o) < lasts_driven / 5) begin
            errors++;
            $display("test %0d: expected row write never arrived within 20 cycles", cur_test);
        end
    endtask

    task automatic read_row(input logic [63:0] addr, input logic [63:0] exp_row);
        @(posedge clk);
        rd_en_i   <= 1'b1;
        rd_addr_i <= addr[fc2_pkg::ROW_AW-1:0];
        // new word only appears at the edge that samples rd_en_i
        @(negedge clk);
        check_value($sformatf("rd_data_o[%0d]", addr), 64'(rd_data_o), 64'(last_rd));
        @(posedge clk);
        rd_en_i   <= 1'b0;
        @(negedge clk);
        check_value($sformatf("rd_data_o[%0d]", addr), 64'(rd_data_o), exp_row);
        last_rd = exp_row[fc2_pkg::ROW_W-1:0];
    endtask

    task automatic finish_test();
        $display("test %0d done, %0d errors", cur_test, errors - test_err0);
        tests_run++;
        reading = 0;
    endtask

    initial begin
        int idx;
        reset_n    <= 1'b0;
        in_valid_i <= 1'b0;
        in_last_i  <= 1'b0;
        feature_i  <= '0;
        weight_i   <= '0;
        rd_en_i    <= 1'b0;
        rd_addr_i  <= '0;
        load_stimulus();
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        for (idx = 0; idx < rec_kind.size(); idx++) begin
            if (rec_kind[idx] == "T") begin
                if (in_test) begin
                    finish_test();
                end
                in_test   = 1;
                cur_test  = int'(rec_a[idx]);
                test_err0 = errors;
            end else if (rec_kind[idx] == "B") begin
                // test 5 streams its beats with no gaps
                drive_beat(rec_a[idx], rec_b[idx], rec_c[idx], cur_test != 5);
            end else begin
                if (!reading) begin
                    wait_for_rows();
                    reading = 1;
                end
                read_row(rec_a[idx], rec_b[idx]);
            end
        end
        if (in_test) begin
            finish_test();
        end
        repeat (2) @(posedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog budget scales with the number of beats in the file
    initial begin
        int limit;
        #1;
        limit = 40 * beat_lines + 400;
        repeat (limit) @(posedge clk);
        $display("timeout, run still going after %0d cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
